// ==== all.f ====
crc_pkg.sv
host_interface.sv
crc_input_buffer.sv
crc_unit.sv
crc_ahb_top.sv
tb_crc_ahb.sv

// ==== tb_crc_ahb.sv ====
/*
 * Self-checking testbench for the AHB-Lite CRC calculator as the only slave on the bus
 * HREADY follows HREADYOUT; narrow DR writes carry data on the low byte lanes
 */
`timescale 1ns/1ps
`default_nettype none

module tb_crc_ahb;

	logic                HCLK = 1'b0;
	logic                HRESETn;
	logic                HSELx;
	logic                HREADY;
	logic                HWRITE;
	logic [1:0]          HTRANS;
	logic [2:0]          HSIZE;
	logic [31:0]         HADDR;
	crc_pkg::word_t      HWDATA;
	crc_pkg::word_t      HRDATA;
	logic                HREADYOUT;
	logic                HRESP;

	crc_pkg::word_t      lcg_state = 32'he64;
	int                  errors = 0;
	int                  checks = 0;

	// Reference model registers
	crc_pkg::word_t      m_crc;
	crc_pkg::word_t      m_init;
	crc_pkg::word_t      m_poly;
	crc_pkg::byte_t      m_idr;
	crc_pkg::poly_size_t m_size;
	crc_pkg::rev_in_t    m_rev_in;
	logic                m_rev_out;

	crc_ahb_top dut_i (.*);

	always #50 HCLK = ~HCLK;

	// Only one slave so the bus ready is its own
	assign HREADY = HREADYOUT;

	//////////////////////////////
	// Reference model
	//////////////////////////////

	function automatic crc_pkg::word_t lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		// Returns the state with its halves swapped
		return {lcg_state[15:0], lcg_state[31:16]};
	endfunction

	function automatic int width_bits(crc_pkg::poly_size_t s);
		case (s)
			2'd0:    return 32;
			2'd1:    return 16;
			2'd2:    return 8;
			default: return 7;
		endcase
	endfunction

	function automatic crc_pkg::word_t width_mask(crc_pkg::poly_size_t s);
		int w;
		w = width_bits(s);
		if (w == 32)
			return 32'hFFFF_FFFF;
		return (32'h1 << w) - 32'h1;
	endfunction

	// Mirror bits inside each span of 8, 16 or 32 bits
	function automatic crc_pkg::word_t reverse_input(crc_pkg::word_t d, crc_pkg::rev_in_t r);
		crc_pkg::word_t res;
		int span;
		case (r)
			2'd1:    span = 8;
			2'd2:    span = 16;
			2'd3:    span = 32;
			default: span = 1;
		endcase
		for (int i = 0; i < 32; i++)
			res[i] = d[(i / span) * span + span - 1 - (i % span)];
		return res;
	endfunction

	// Shifts MSB first with feedback from the top bit of the active width
	function automatic crc_pkg::word_t fold_byte(crc_pkg::word_t crc, crc_pkg::byte_t b);
		int w;
		crc_pkg::word_t mask;
		logic fb;
		w = width_bits(m_size);
		mask = width_mask(m_size);
		for (int i = 7; i >= 0; i--)
		begin
			fb = crc[w - 1] ^ b[i];
			crc = (crc << 1) & mask;
			if (fb)
				crc = crc ^ (m_poly & mask);
		end
		return crc;
	endfunction

	function automatic crc_pkg::word_t model_crc_out();
		int w;
		crc_pkg::word_t res;
		w = width_bits(m_size);
		res = '0;
		if (!m_rev_out)
			return m_crc & width_mask(m_size);
		for (int i = 0; i < w; i++)
			res[i] = m_crc[w - 1 - i];
		return res;
	endfunction

	task automatic model_write(input crc_pkg::reg_addr_t idx, input crc_pkg::bus_size_t size,
		input crc_pkg::word_t data);
		crc_pkg::word_t rev;
		case (idx)
			crc_pkg::CRC_DR:
			begin
				rev = reverse_input(data, m_rev_in);
				for (int k = 0; k < (1 << size); k++)
					m_crc = fold_byte(m_crc, rev[8 * k +: 8]);
			end
			crc_pkg::CRC_IDR: m_idr = data[7:0];
			crc_pkg::CRC_CR:
			begin
				// Restart happens under the width still in force
				if (data[0])
					m_crc = m_init & width_mask(m_size);
				m_size    = data[4:3];
				m_rev_in  = data[6:5];
				m_rev_out = data[7];
			end
			crc_pkg::CRC_INIT:
			begin
				m_init = data;
				m_crc  = data & width_mask(m_size);
			end
			crc_pkg::CRC_POL: m_poly = data;
			default: ;
		endcase
	endtask

	function automatic crc_pkg::word_t model_read(crc_pkg::reg_addr_t idx);
		case (idx)
			crc_pkg::CRC_DR:   return model_crc_out();
			crc_pkg::CRC_IDR:  return {24'h0, m_idr};
			crc_pkg::CRC_CR:   return {24'h0, m_rev_out, m_rev_in, m_size, 3'b000};
			crc_pkg::CRC_INIT: return m_init;
			crc_pkg::CRC_POL:  return m_poly;
			default:           return '0;
		endcase
	endfunction

	//////////////////////////////
	// Bus master
	//////////////////////////////

	task automatic end_run();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	endtask

	// Polls HREADYOUT on falling edges for up to 50 cycles
	task automatic wait_ready();
		int cycles;
		cycles = 0;
		while (!HREADYOUT && cycles < 50)
		begin
			@(negedge HCLK);
			cycles++;
		end
		if (!HREADYOUT)
		begin
			errors++;
			$display("Bus stalled: HREADYOUT stayed low for 50 cycles at %0t ns", $time);
			end_run();
		end
	endtask

	task automatic bus_xfer(input logic write, input crc_pkg::reg_addr_t idx,
		input crc_pkg::bus_size_t size, input crc_pkg::word_t wdata,
		output crc_pkg::word_t rdata);
		// Address phase
		@(negedge HCLK);
		HSELx  = 1'b1;
		HTRANS = crc_pkg::HTRANS_NONSEQ;
		HWRITE = write;
		HSIZE  = {1'b0, size};
		HADDR  = {27'h0, idx, 2'b00};
		wait_ready();
		// Data phase with the bus idle behind it
		@(negedge HCLK);
		HSELx  = 1'b0;
		HTRANS = crc_pkg::HTRANS_IDLE;
		HWDATA = write ? wdata : '0;
		wait_ready();
		rdata = HRDATA;
		checks++;
		assert (HRESP == crc_pkg::HRESP_OKAY)
		else
		begin
			errors++;
			$display("ERR %0t ns: HRESP is not OKAY", $time);
		end
	endtask

	task automatic write_reg(input crc_pkg::reg_addr_t idx, input crc_pkg::bus_size_t size,
		input crc_pkg::word_t data);
		crc_pkg::word_t unused;
		bus_xfer(1'b1, idx, size, data, unused);
		model_write(idx, size, data);
	endtask

	task automatic read_check(input crc_pkg::reg_addr_t idx, input string what);
		crc_pkg::word_t got;
		crc_pkg::word_t exp;
		bus_xfer(1'b0, idx, 2'd2, '0, got);
		exp = model_read(idx);
		checks++;
		assert (got === exp)
		else
		begin
			errors++;
			$display("ERR %0t ns: %s read %h, expected %h", $time, what, got, exp);
		end
	endtask

	//////////////////////////////
	// Test sequence
	//////////////////////////////

	initial
	begin
		crc_pkg::word_t d;
		crc_pkg::bus_size_t sz;
		HRESETn = 1'b0;
		HSELx   = 1'b0;
		HTRANS  = crc_pkg::HTRANS_IDLE;
		HWRITE  = 1'b0;
		HSIZE   = 3'd0;
		HADDR   = '0;
		HWDATA  = '0;
		m_crc     = 32'hFFFF_FFFF;
		m_init    = 32'hFFFF_FFFF;
		m_poly    = 32'h04C1_1DB7;
		m_idr     = '0;
		m_size    = '0;
		m_rev_in  = '0;
		m_rev_out = 1'b0;
		repeat (16) @(negedge HCLK);
		HRESETn = 1'b1;

		// Reset values
		read_check(crc_pkg::CRC_INIT, "INIT after reset");
		read_check(crc_pkg::CRC_POL, "POL after reset");
		read_check(crc_pkg::CRC_CR, "CR after reset");
		read_check(crc_pkg::CRC_IDR, "IDR after reset");
		read_check(crc_pkg::CRC_DR, "DR after reset");
		read_check(3'd3, "unmapped slot after reset");

		// Readback of random settings
		repeat (8)
		begin
			write_reg(crc_pkg::CRC_POL, 2'd2, lcg_next());
			read_check(crc_pkg::CRC_POL, "POL");
			write_reg(crc_pkg::CRC_INIT, 2'd2, lcg_next());
			read_check(crc_pkg::CRC_INIT, "INIT");
			write_reg(crc_pkg::CRC_IDR, 2'd2, lcg_next());
			read_check(crc_pkg::CRC_IDR, "IDR");
			write_reg(crc_pkg::CRC_CR, 2'd2, lcg_next());
			read_check(crc_pkg::CRC_CR, "CR");
			read_check(crc_pkg::CRC_DR, "DR after setup");
		end

		// Random streams of back to back writes with reads in between
		repeat (6)
		begin
			write_reg(crc_pkg::CRC_POL, 2'd2, lcg_next() | 32'h1);
			write_reg(crc_pkg::CRC_INIT, 2'd2, lcg_next());
			write_reg(crc_pkg::CRC_CR, 2'd2, (lcg_next() & 32'hF8) | 32'h1);
			repeat (16)
			begin
				d  = lcg_next();
				sz = crc_pkg::bus_size_t'(lcg_next() % 3);
				write_reg(crc_pkg::CRC_DR, sz, d);
				if (lcg_next() & 32'h1)
					read_check(crc_pkg::CRC_DR, "DR in stream");
			end
			read_check(crc_pkg::CRC_DR, "DR at stream end");
		end

		// Restart by CR bit 0 and then by a new initial value
		write_reg(crc_pkg::CRC_DR, 2'd2, lcg_next());
		read_check(crc_pkg::CRC_DR, "DR before restart");
		write_reg(crc_pkg::CRC_CR, 2'd2, {24'h0, m_rev_out, m_rev_in, m_size, 3'b001});
		read_check(crc_pkg::CRC_DR, "DR after CR restart");
		write_reg(crc_pkg::CRC_DR, 2'd1, lcg_next());
		write_reg(crc_pkg::CRC_INIT, 2'd2, lcg_next());
		read_check(crc_pkg::CRC_DR, "DR after INIT write");
		write_reg(crc_pkg::CRC_DR, 2'd0, lcg_next());
		read_check(crc_pkg::CRC_DR, "DR after restart data");

		end_run();
	end

endmodule

`default_nettype wire

// ==== crc_ahb_top.sv ====
/*
 * CRC calculator with an AHB-Lite slave port, single transfers only
 */
`timescale 1ns/1ps
`default_nettype none

module crc_ahb_top
(
	input  logic            HCLK,
	input  logic            HRESETn,
	input  logic            HSELx,
	input  logic            HREADY,
	input  logic            HWRITE,
	input  logic [1:0]      HTRANS,
	input  logic [2:0]      HSIZE,
	input  logic [31:0]     HADDR,
	input  crc_pkg::word_t  HWDATA,
	output crc_pkg::word_t  HRDATA,
	output logic            HREADYOUT,
	output logic            HRESP
);

	// Bus front end to datapath
	crc_pkg::word_t       bus_wr;
	crc_pkg::bus_size_t   bus_size;
	crc_pkg::rev_in_t     rev_in_type;
	logic                 rev_out_type;
	crc_pkg::poly_size_t  crc_poly_size;
	logic                 buffer_write_en;
	logic                 crc_init_en;
	logic                 crc_poly_en;
	logic                 crc_idr_en;
	logic                 reset_chain;

	// Buffer to CRC unit and back to the bus
	logic                 byte_valid;
	crc_pkg::byte_t       byte_data;
	logic                 buffer_full;
	logic                 chain_busy;

	// CRC unit readback
	crc_pkg::word_t       crc_out;
	crc_pkg::word_t       crc_init_out;
	crc_pkg::word_t       crc_poly_out;
	crc_pkg::byte_t       crc_idr_out;

	host_interface host_interface_i (.*);

	crc_input_buffer crc_input_buffer_i (.*);

	crc_unit crc_unit_i (.*);

endmodule

`default_nettype wire

// ==== crc_unit.sv ====
/*
 * Programmable CRC engine, one byte per cycle, data MSB first, non-reflected
 * Widths of 32, 16, 8 and 7 bits; polynomial and init are masked to the width
 */
`timescale 1ns/1ps
`default_nettype none

module crc_unit
(
	input  logic                 HCLK,
	input  logic                 HRESETn,
	input  crc_pkg::word_t       bus_wr,
	input  logic                 crc_init_en,
	input  logic                 crc_poly_en,
	input  logic                 crc_idr_en,
	input  logic                 reset_chain,
	input  logic                 byte_valid,
	input  crc_pkg::byte_t       byte_data,
	input  crc_pkg::poly_size_t  crc_poly_size,
	input  logic                 rev_out_type,
	output crc_pkg::word_t       crc_out,
	output crc_pkg::word_t       crc_init_out,
	output crc_pkg::word_t       crc_poly_out,
	output crc_pkg::byte_t       crc_idr_out
);

	crc_pkg::word_t init_ff;
	crc_pkg::word_t poly_ff;
	crc_pkg::byte_t idr_ff;
	crc_pkg::word_t crc_ff;

	crc_pkg::word_t crc_next;
	crc_pkg::word_t crc_rev;
	crc_pkg::word_t width_mask;
	// Index of the top CRC bit for the active width
	logic [4:0]     top_bit;
	logic           feedback;

	//////////////////////////////
	// Width decode
	//////////////////////////////

	always_comb
	begin
		case (crc_poly_size)
			2'd0:    top_bit = 5'd31;
			2'd1:    top_bit = 5'd15;
			2'd2:    top_bit = 5'd7;
			default: top_bit = 5'd6;
		endcase
	end

	assign width_mask = 32'hFFFF_FFFF >> (5'd31 - top_bit);

	// Eight shift steps per byte, data bit 7 first
	always_comb
	begin
		crc_next = crc_ff;
		for (int i = 7; i >= 0; i--)
		begin
			feedback = crc_next[top_bit] ^ byte_data[i];
			crc_next = (crc_next << 1) & width_mask;
			if (feedback)
				crc_next = crc_next ^ (poly_ff & width_mask);
		end
	end

	//////////////////////////////
	// Registers
	//////////////////////////////

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			init_ff <= crc_pkg::RESET_INIT;
			poly_ff <= crc_pkg::RESET_POLY;
			idr_ff  <= '0;
		end
		else
		begin
			if (crc_init_en)
				init_ff <= bus_wr;
			if (crc_poly_en)
				poly_ff <= bus_wr;
			// IDR is scratch, low byte only
			if (crc_idr_en)
				idr_ff <= bus_wr[7:0];
		end
	end

	// New init value also restarts the chain
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			crc_ff <= crc_pkg::RESET_INIT;
		else if (crc_init_en)
			crc_ff <= bus_wr & width_mask;
		else if (reset_chain)
			crc_ff <= init_ff & width_mask;
		else if (byte_valid)
			crc_ff <= crc_next;
	end

	// Output reversal over the active width
	always_comb
	begin
		for (int i = 0; i < 32; i++)
			crc_rev[i] = crc_ff[31 - i];
	end

	assign crc_out = rev_out_type ? (crc_rev >> (5'd31 - top_bit)) : (crc_ff & width_mask);
	assign crc_init_out = init_ff;
	assign crc_poly_out = poly_ff;
	assign crc_idr_out  = idr_ff;

	// After any load or update at a steady width, bits above the width are clear
	a_upper_clear: assert property (@(posedge HCLK) disable iff (!HRESETn)
		(crc_init_en || reset_chain || byte_valid) |=>
		(!$stable(crc_poly_size) || ((crc_ff & ~width_mask) == '0)));

endmodule

`default_nettype wire

// ==== crc_input_buffer.sv ====
/*
 * One-word input buffer, hands the CRC unit one byte per cycle, low byte first
 * No back-pressure toward the CRC unit; the bus side waits on buffer_full
 */
`timescale 1ns/1ps
`default_nettype none

module crc_input_buffer
(
	input  logic                HCLK,
	input  logic                HRESETn,
	input  logic                buffer_write_en,
	input  crc_pkg::word_t      bus_wr,
	input  crc_pkg::bus_size_t  bus_size,
	input  crc_pkg::rev_in_t    rev_in_type,
	output logic                byte_valid,
	output crc_pkg::byte_t      byte_data,
	output logic                buffer_full,
	output logic                chain_busy
);

	crc_pkg::word_t data_ff;
	crc_pkg::word_t data_rev;
	logic [2:0]     count_ff;
	logic [2:0]     load_count;
	// Last byte is in the CRC register this cycle
	logic           last_ff;

	// Bit reversal over the chosen span, before the bytes are split
	always_comb
	begin
		for (int i = 0; i < 32; i++)
		begin
			case (rev_in_type)
				2'd1:    data_rev[i] = bus_wr[(i & 24) | (7 - (i & 7))];
				2'd2:    data_rev[i] = bus_wr[(i & 16) | (15 - (i & 15))];
				2'd3:    data_rev[i] = bus_wr[31 - i];
				default: data_rev[i] = bus_wr[i];
			endcase
		end
	end

	// Bytes per transfer
	always_comb
	begin
		case (bus_size)
			2'd0:    load_count = 3'd1;
			2'd1:    load_count = 3'd2;
			default: load_count = 3'd4;
		endcase
	end

	// Byte counter
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			count_ff <= '0;
			last_ff  <= 1'b0;
		end
		else
		begin
			last_ff <= (count_ff == 3'd1);
			if (buffer_write_en)
				count_ff <= load_count;
			else if (count_ff != 3'd0)
				count_ff <= count_ff - 3'd1;
		end
	end

	// Data shifts down one byte per issued byte
	always_ff @(posedge HCLK)
	begin
		if (buffer_write_en)
			data_ff <= data_rev;
		else if (byte_valid)
			data_ff <= data_ff >> 8;
	end

	assign buffer_full = (count_ff != 3'd0);
	assign byte_valid  = buffer_full;
	assign byte_data   = data_ff[7:0];
	assign chain_busy  = buffer_full || last_ff;

	// Host must hold a DR write until the buffer is empty
	a_no_overrun: assert property (@(posedge HCLK) disable iff (!HRESETn)
		buffer_write_en |-> !buffer_full);

endmodule

`default_nettype wire

// ==== host_interface.sv ====
/*
 * AHB-Lite slave front end for single NONSEQ transfers; SEQ and BUSY are ignored
 * HRESP is always OKAY; narrow DR writes must use the low byte lanes of HWDATA
 */
`timescale 1ns/1ps
`default_nettype none

module host_interface
(
	input  logic                 HCLK,
	input  logic                 HRESETn,
	input  logic                 HSELx,
	input  logic                 HREADY,
	input  logic                 HWRITE,
	input  logic [1:0]           HTRANS,
	input  logic [2:0]           HSIZE,
	input  logic [31:0]          HADDR,
	input  crc_pkg::word_t       HWDATA,
	input  crc_pkg::word_t       crc_out,
	input  crc_pkg::word_t       crc_init_out,
	input  crc_pkg::word_t       crc_poly_out,
	input  crc_pkg::byte_t       crc_idr_out,
	input  logic                 buffer_full,
	input  logic                 chain_busy,
	output crc_pkg::word_t       HRDATA,
	output logic                 HREADYOUT,
	output logic                 HRESP,
	output crc_pkg::word_t       bus_wr,
	output crc_pkg::bus_size_t   bus_size,
	output crc_pkg::rev_in_t     rev_in_type,
	output logic                 rev_out_type,
	output crc_pkg::poly_size_t  crc_poly_size,
	output logic                 buffer_write_en,
	output logic                 crc_init_en,
	output logic                 crc_poly_en,
	output logic                 crc_idr_en,
	output logic                 reset_chain
);

	// Address phase copies
	logic                hselx_pp;
	logic [1:0]          htrans_pp;
	logic                hwrite_pp;
	crc_pkg::reg_addr_t  haddr_pp;
	crc_pkg::bus_size_t  hsize_pp;

	// Control register holds {rev_out, rev_in, poly_size}
	logic [4:0]          crc_cr_ff;
	crc_pkg::word_t      crc_cr_rd;

	logic sample_bus;
	logic nonseq_pp;
	logic write_en;
	logic read_en;
	logic dr_write_req;
	logic dr_read_req;
	logic init_write_req;
	logic crc_cr_en;

	//////////////////////////////
	// Address phase pipeline
	//////////////////////////////

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			hselx_pp  <= 1'b0;
			htrans_pp <= crc_pkg::HTRANS_IDLE;
		end
		else if (sample_bus)
		begin
			hselx_pp  <= HSELx;
			htrans_pp <= HTRANS;
		end
	end

	always_ff @(posedge HCLK)
	begin
		if (sample_bus)
		begin
			haddr_pp  <= HADDR[4:2];
			hsize_pp  <= HSIZE[1:0];
			hwrite_pp <= HWRITE;
		end
	end

	// Only NONSEQ transfers reach the registers
	assign nonseq_pp = (htrans_pp == crc_pkg::HTRANS_NONSEQ);
	assign write_en  = hselx_pp && nonseq_pp && hwrite_pp;
	assign read_en   = hselx_pp && nonseq_pp && !hwrite_pp;

	// Requests that may have to wait
	assign dr_write_req   = write_en && (haddr_pp == crc_pkg::CRC_DR);
	assign dr_read_req    = read_en && (haddr_pp == crc_pkg::CRC_DR);
	assign init_write_req = write_en && (haddr_pp == crc_pkg::CRC_INIT);

	// Strobes fire only in the cycle the data phase completes
	assign buffer_write_en = dr_write_req && !buffer_full;
	assign crc_init_en     = init_write_req && !chain_busy;
	assign crc_idr_en      = write_en && (haddr_pp == crc_pkg::CRC_IDR);
	assign crc_poly_en     = write_en && (haddr_pp == crc_pkg::CRC_POL);
	assign crc_cr_en       = write_en && (haddr_pp == crc_pkg::CRC_CR);

	// Wait states
	// DR write waits for an empty buffer and DR read or INIT write for a final CRC
	assign HREADYOUT = !((dr_write_req && buffer_full) ||
		(dr_read_req && chain_busy) ||
		(init_write_req && chain_busy));
	assign sample_bus = HREADY && HREADYOUT;
	assign HRESP      = crc_pkg::HRESP_OKAY;

	// Write data is used unregistered in the data phase
	assign bus_wr   = HWDATA;
	assign bus_size = hsize_pp;

	//////////////////////////////
	// Read mux
	//////////////////////////////

	// Bit 0 and bits 2..1 read as zero
	assign crc_cr_rd = {24'h0, crc_cr_ff, 3'b000};

	always_comb
	begin
		case (haddr_pp)
			crc_pkg::CRC_DR:   HRDATA = crc_out;
			crc_pkg::CRC_IDR:  HRDATA = {24'h0, crc_idr_out};
			crc_pkg::CRC_CR:   HRDATA = crc_cr_rd;
			crc_pkg::CRC_INIT: HRDATA = crc_init_out;
			crc_pkg::CRC_POL:  HRDATA = crc_poly_out;
			default:           HRDATA = '0;
		endcase
	end

	// Control register fields come from HWDATA[7:3]
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			crc_cr_ff <= crc_pkg::RESET_CR;
		else if (crc_cr_en)
			crc_cr_ff <= HWDATA[7:3];
	end

	// Bit 0 restarts the chain and is not stored
	assign reset_chain   = crc_cr_en && HWDATA[0];
	assign crc_poly_size = crc_cr_ff[1:0];
	assign rev_in_type   = crc_cr_ff[3:2];
	assign rev_out_type  = crc_cr_ff[4];

	// A blocked DR write stalls until the buffer drains within four cycles
	a_dr_stall: assert property (@(posedge HCLK) disable iff (!HRESETn)
		(dr_write_req && buffer_full) |-> (!HREADYOUT ##[1:4] HREADYOUT));

	// Transfers wider than a word are not supported
	a_size: assert property (@(posedge HCLK) disable iff (!HRESETn)
		(sample_bus && HSELx && (HTRANS == crc_pkg::HTRANS_NONSEQ)) |-> !HSIZE[2]);

endmodule

`default_nettype wire

// ==== crc_pkg.sv ====
/*
 * Register map, AHB encodings and reset values shared by the CRC calculator
 * Registers sit on word addresses, HADDR[4:2] selects one of eight slots
 */
`default_nettype none

package crc_pkg;

	//////////////////////////////
	// Width types
	//////////////////////////////

	// Bus data word, also CRC, polynomial and initial value
	typedef logic [31:0] word_t;

	// One data byte from the input buffer to the CRC unit
	typedef logic [7:0] byte_t;

	// Register index, HADDR[4:2]
	typedef logic [2:0] reg_addr_t;

	// Polynomial width code
	// 0 = 32 bit, 1 = 16 bit, 2 = 8 bit, 3 = 7 bit
	typedef logic [1:0] poly_size_t;

	// Input reversal code
	// 0 = none, 1 = per byte, 2 = per halfword, 3 = whole word
	typedef logic [1:0] rev_in_t;

	// Transfer size, low bits of HSIZE
	// 0 = byte, 1 = halfword, 2 = word
	typedef logic [1:0] bus_size_t;

	//////////////////////////////
	// Register map
	//////////////////////////////

	localparam reg_addr_t CRC_DR   = 3'h0;
	localparam reg_addr_t CRC_IDR  = 3'h1;
	localparam reg_addr_t CRC_CR   = 3'h2;
	localparam reg_addr_t CRC_INIT = 3'h4;
	localparam reg_addr_t CRC_POL  = 3'h5;

	// AHB transfer types
	localparam logic [1:0] HTRANS_IDLE   = 2'b00;
	localparam logic [1:0] HTRANS_BUSY   = 2'b01;
	localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
	localparam logic [1:0] HTRANS_SEQ    = 2'b11;

	// Only response ever given
	localparam logic HRESP_OKAY = 1'b0;

	// Reset values
	// CR holds {rev_out, rev_in, poly_size}
	localparam logic [4:0] RESET_CR   = 5'h00;
	localparam word_t      RESET_INIT = 32'hFFFF_FFFF;
	localparam word_t      RESET_POLY = 32'h04C1_1DB7;

endpackage

`default_nettype wire
